// ==== design/sha2_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 32-bit modes keep their words in the low half of a 64-bit word
// ~~~~~~~~~~~~~~~~~~~~
package sha2_pkg;

    localparam int WORD_W      = 64;
    localparam int BLOCK_WORDS = 16;
    localparam int ROUNDS_32   = 64;
    localparam int ROUNDS_64   = 80;
    localparam int DIGEST_W    = 512;
    localparam int CNT_W       = 7;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // bit 1 set means 64-bit word family
    typedef enum logic [1:0] {
        SHA_224 = 2'd0,
        SHA_256 = 2'd1,
        SHA_384 = 2'd2,
        SHA_512 = 2'd3
    } sha2_mode_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ABSORB = 2'd1, // rounds 0..15, one per host word
        EXPAND = 2'd2,
        FOLD   = 2'd3
    } sha2_state_t;

    function automatic word_t rotr64(input word_t x, input int n);
        return (x >> n) | (x << (64 - n));
    endfunction

    // rotate of the low half, upper half returned as zero
    function automatic word_t rotr32(input word_t x, input int n);
        logic [31:0] lo;
        lo = x[31:0];
        return {32'b0, (lo >> n) | (lo << (32 - n))};
    endfunction

    function automatic word_t word_mask(input sha2_mode_t mode);
        return mode[1] ? {WORD_W{1'b1}} : {32'b0, 32'hffff_ffff};
    endfunction

endpackage

// ==== design/sha2_const_rom.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// purely combinational; 32-bit constants are the upper halves of k
// ~~~~~~~~~~~~~~~~~~~~
module sha2_const_rom (
    input  sha2_pkg::cnt_t           round_idx_i,
    input  sha2_pkg::sha2_mode_t     mode_i,
    output sha2_pkg::word_t          k_t_o,
    output sha2_pkg::word_t [7:0]    iv_o
);

    localparam logic [63:0] K_TAB [80] = '{
        64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
        64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
        64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
        64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
        64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
        64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
        64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
        64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
        64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
        64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
        64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
        64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
        64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
        64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
        64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
        64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
        64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
        64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
        64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
        64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
    };

    // index 0 is a, index 7 is h
    localparam logic [63:0] IV_384 [8] = '{
        64'hcbbb9d5dc1059ed8,
        64'h629a292a367cd507,
        64'h9159015a3070dd17,
        64'h152fecd8f70e5939,
        64'h67332667ffc00b31,
        64'h8eb44a8768581511,
        64'hdb0c2e0d64f98fa7,
        64'h47b5481dbefa4fa4
    };

    localparam logic [63:0] IV_512 [8] = '{
        64'h6a09e667f3bcc908,
        64'hbb67ae8584caa73b,
        64'h3c6ef372fe94f82b,
        64'ha54ff53a5f1d36f1,
        64'h510e527fade682d1,
        64'h9b05688c2b3e6c1f,
        64'h1f83d9abfb41bd6b,
        64'h5be0cd19137e2179
    };

    logic [63:0] k_full;

    always_comb begin
        if (round_idx_i < sha2_pkg::cnt_t'(sha2_pkg::ROUNDS_64)) begin
            k_full = K_TAB[round_idx_i];
        end else begin
            k_full = '0;
        end
        k_t_o = mode_i[1] ? k_full : {32'b0, k_full[63:32]};
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (mode_i)
                sha2_pkg::SHA_224: iv_o[i] = {32'b0, IV_384[i][31:0]};   // low halves
                sha2_pkg::SHA_256: iv_o[i] = {32'b0, IV_512[i][63:32]};  // high halves
                sha2_pkg::SHA_384: iv_o[i] = IV_384[i];
                default:           iv_o[i] = IV_512[i];
            endcase
        end
    end

endmodule

// ==== design/sha2_msg_schedule.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// host bytes arrive little-endian, first byte in bits 7:0
// ~~~~~~~~~~~~~~~~~~~~
module sha2_msg_schedule (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  sha2_pkg::word_t      in_data_i,
    input  logic                 word_take_i,
    input  logic                 expand_en_i,
    input  sha2_pkg::sha2_mode_t mode_i,
    output sha2_pkg::word_t      w_t_o
);

    // win_q[0] is W(t-1), win_q[15] is W(t-16)
    sha2_pkg::word_t [15:0] win_q;
    sha2_pkg::word_t        swapped;
    sha2_pkg::word_t        sig0;
    sha2_pkg::word_t        sig1;
    sha2_pkg::word_t        expanded;

    always_comb begin
        swapped = '0;
        if (mode_i[1]) begin
            for (int i = 0; i < 8; i++) begin
                swapped[8*i +: 8] = in_data_i[8*(7-i) +: 8];
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                swapped[8*i +: 8] = in_data_i[8*(3-i) +: 8]; // low half only
            end
        end
    end

    always_comb begin
        if (mode_i[1]) begin
            sig0 = sha2_pkg::rotr64(win_q[14], 1) ^ sha2_pkg::rotr64(win_q[14], 8)
                 ^ (win_q[14] >> 7);
            sig1 = sha2_pkg::rotr64(win_q[1], 19) ^ sha2_pkg::rotr64(win_q[1], 61)
                 ^ (win_q[1] >> 6);
        end else begin
            sig0 = sha2_pkg::rotr32(win_q[14], 7) ^ sha2_pkg::rotr32(win_q[14], 18)
                 ^ (win_q[14] >> 3);
            sig1 = sha2_pkg::rotr32(win_q[1], 17) ^ sha2_pkg::rotr32(win_q[1], 19)
                 ^ (win_q[1] >> 10);
        end
        expanded = (sig1 + win_q[6] + sig0 + win_q[15]) & sha2_pkg::word_mask(mode_i);
    end

    assign w_t_o = expand_en_i ? expanded : swapped;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            win_q <= '0;
        end else if (word_take_i || expand_en_i) begin
            win_q <= {win_q[14:0], w_t_o};
        end
    end

endmodule

// ==== design/sha2_compress.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// one round per round_en; seed takes a-h from H (or the IV on init)
// ~~~~~~~~~~~~~~~~~~~~
module sha2_compress (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   init_i,
    input  logic                   seed_i,
    input  logic                   round_en_i,
    input  logic                   fold_i,
    input  sha2_pkg::sha2_mode_t   mode_i,
    input  sha2_pkg::word_t        w_t_i,
    input  sha2_pkg::word_t        k_t_i,
    input  sha2_pkg::word_t [7:0]  iv_i,
    output sha2_pkg::word_t [7:0]  hash_o
);

    sha2_pkg::word_t [7:0] hash_q;  // chaining state
    sha2_pkg::word_t [7:0] work_q;  // a..h, index 0 is a
    sha2_pkg::word_t [7:0] src;
    sha2_pkg::word_t       mask;
    sha2_pkg::word_t       big_s0;
    sha2_pkg::word_t       big_s1;
    sha2_pkg::word_t       ch;
    sha2_pkg::word_t       maj;
    sha2_pkg::word_t       t1;
    sha2_pkg::word_t       t2;
    sha2_pkg::word_t       next_a;
    sha2_pkg::word_t       next_e;

    always_comb begin
        mask = sha2_pkg::word_mask(mode_i);

        // first round of a block reads straight from H so no seed cycle is lost
        if (seed_i) begin
            src = init_i ? iv_i : hash_q;
        end else begin
            src = work_q;
        end

        if (mode_i[1]) begin
            big_s0 = sha2_pkg::rotr64(src[0], 28) ^ sha2_pkg::rotr64(src[0], 34)
                   ^ sha2_pkg::rotr64(src[0], 39);
            big_s1 = sha2_pkg::rotr64(src[4], 14) ^ sha2_pkg::rotr64(src[4], 18)
                   ^ sha2_pkg::rotr64(src[4], 41);
        end else begin
            big_s0 = sha2_pkg::rotr32(src[0], 2) ^ sha2_pkg::rotr32(src[0], 13)
                   ^ sha2_pkg::rotr32(src[0], 22);
            big_s1 = sha2_pkg::rotr32(src[4], 6) ^ sha2_pkg::rotr32(src[4], 11)
                   ^ sha2_pkg::rotr32(src[4], 25);
        end

        ch  = (src[4] & src[5]) ^ (~src[4] & src[6]);
        maj = (src[0] & src[1]) ^ (src[0] & src[2]) ^ (src[1] & src[2]);
        t1  = src[7] + big_s1 + ch + k_t_i + w_t_i;
        t2  = big_s0 + maj;

        next_a = (t1 + t2) & mask;
        next_e = (src[3] + t1) & mask;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hash_q <= '0;
            work_q <= '0;
        end else begin
            if (init_i) begin
                hash_q <= iv_i;
            end else if (fold_i) begin
                for (int i = 0; i < 8; i++) begin
                    hash_q[i] <= (hash_q[i] + work_q[i]) & mask;
                end
            end

            if (round_en_i) begin
                work_q <= {src[6], src[5], src[4], next_e, src[2], src[1], src[0], next_a};
            end
        end
    end

    assign hash_o = hash_q;

endmodule

// ==== design/sha2_round_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// mode taken on the first word only, last flag on each block's first word
// ~~~~~~~~~~~~~~~~~~~~
module sha2_round_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 in_valid_i,
    input  sha2_pkg::sha2_mode_t in_mode_i,
    input  logic                 in_last_i,
    input  logic                 out_busy_i,
    output logic                 in_ready_o,
    output logic                 word_take_o,
    output logic                 expand_en_o,
    output logic                 round_en_o,
    output sha2_pkg::cnt_t       round_idx_o,
    output logic                 init_o,
    output logic                 seed_o,
    output logic                 fold_o,
    output logic                 digest_load_o,
    output sha2_pkg::sha2_mode_t mode_o
);

    sha2_pkg::sha2_state_t state_q;
    sha2_pkg::cnt_t        cnt_q;
    sha2_pkg::cnt_t        last_round;
    sha2_pkg::sha2_mode_t  mode_q;
    logic                  last_q;

    always_comb begin
        in_ready_o = ((state_q == sha2_pkg::IDLE) && !out_busy_i)
                   || (state_q == sha2_pkg::ABSORB);
        word_take_o   = in_valid_i && in_ready_o;
        expand_en_o   = (state_q == sha2_pkg::EXPAND);
        round_en_o    = word_take_o || expand_en_o;
        round_idx_o   = cnt_q;
        init_o        = word_take_o && (state_q == sha2_pkg::IDLE);
        seed_o        = word_take_o && (cnt_q == '0);
        fold_o        = (state_q == sha2_pkg::FOLD);
        digest_load_o = fold_o && last_q;
        mode_o        = (state_q == sha2_pkg::IDLE) ? in_mode_i : mode_q;
        last_round    = mode_q[1] ? sha2_pkg::cnt_t'(sha2_pkg::ROUNDS_64 - 1)
                                  : sha2_pkg::cnt_t'(sha2_pkg::ROUNDS_32 - 1);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= sha2_pkg::IDLE;
            cnt_q   <= '0;
            mode_q  <= sha2_pkg::SHA_256;
            last_q  <= 1'b0;
        end else begin
            if (seed_o) begin
                last_q <= in_last_i;
            end

            case (state_q)
                sha2_pkg::IDLE: begin
                    if (word_take_o) begin
                        mode_q  <= in_mode_i;
                        cnt_q   <= cnt_q + 1'b1;
                        state_q <= sha2_pkg::ABSORB;
                    end
                end
                sha2_pkg::ABSORB: begin
                    if (word_take_o) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == sha2_pkg::cnt_t'(sha2_pkg::BLOCK_WORDS - 1)) begin
                            state_q <= sha2_pkg::EXPAND;
                        end
                    end
                end
                sha2_pkg::EXPAND: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == last_round) begin
                        state_q <= sha2_pkg::FOLD;
                    end
                end
                sha2_pkg::FOLD: begin
                    cnt_q   <= '0;
                    state_q <= last_q ? sha2_pkg::IDLE : sha2_pkg::ABSORB; // next block
                end
            endcase
        end
    end

endmodule

// ==== design/sha2_digest_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data held stable while out_valid_o waits for out_ready_i
// ~~~~~~~~~~~~~~~~~~~~
module sha2_digest_out (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            digest_load_i,
    input  sha2_pkg::sha2_mode_t            mode_i,
    input  sha2_pkg::word_t [7:0]           hash_i,
    input  logic                            out_ready_i,
    output logic [sha2_pkg::DIGEST_W-1:0]   out_data_o,
    output logic                            out_valid_o,
    output logic                            out_busy_o
);

    logic                          load_q;   // H is folded one cycle after the load
    sha2_pkg::sha2_mode_t          mode_q;
    logic [sha2_pkg::DIGEST_W-1:0] packed_d;
    int                            n_words;

    always_comb begin
        case (mode_q)
            sha2_pkg::SHA_224: n_words = 7;
            sha2_pkg::SHA_384: n_words = 6;
            default:           n_words = 8;
        endcase

        // first hash word lands in the highest used slot
        packed_d = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < n_words) begin
                if (mode_q[1]) begin
                    packed_d[64*i +: 64] = hash_i[n_words-1-i];
                end else begin
                    packed_d[32*i +: 32] = hash_i[n_words-1-i][31:0];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            load_q      <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            load_q <= digest_load_i;
            if (load_q) begin
                out_valid_o <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (digest_load_i) begin
            mode_q <= mode_i;
        end
        if (load_q) begin
            out_data_o <= packed_d;
        end
    end

    assign out_busy_o = load_q || out_valid_o;

endmodule

// ==== design/sha2_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// host pads the message; one block in flight, output stalls input
// ~~~~~~~~~~~~~~~~~~~~
module sha2_core (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  sha2_pkg::word_t               in_data_i,
    input  sha2_pkg::sha2_mode_t          in_mode_i,
    input  logic                          in_last_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    output logic [sha2_pkg::DIGEST_W-1:0] out_data_o,
    output logic                          out_valid_o,
    input  logic                          out_ready_i
);

    logic                  word_take;
    logic                  expand_en;
    logic                  round_en;
    logic                  init;
    logic                  seed;
    logic                  fold;
    logic                  digest_load;
    logic                  out_busy;
    sha2_pkg::cnt_t        round_idx;
    sha2_pkg::sha2_mode_t  mode;
    sha2_pkg::word_t       w_t;
    sha2_pkg::word_t       k_t;
    sha2_pkg::word_t [7:0] iv;
    sha2_pkg::word_t [7:0] hash;

    sha2_round_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_mode_i     (in_mode_i),
        .in_last_i     (in_last_i),
        .out_busy_i    (out_busy),
        .in_ready_o    (in_ready_o),
        .word_take_o   (word_take),
        .expand_en_o   (expand_en),
        .round_en_o    (round_en),
        .round_idx_o   (round_idx),
        .init_o        (init),
        .seed_o        (seed),
        .fold_o        (fold),
        .digest_load_o (digest_load),
        .mode_o        (mode)
    );

    sha2_msg_schedule u_sched (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (in_data_i),
        .word_take_i (word_take),
        .expand_en_i (expand_en),
        .mode_i      (mode),
        .w_t_o       (w_t)
    );

    sha2_const_rom u_rom (
        .round_idx_i (round_idx),
        .mode_i      (mode),
        .k_t_o       (k_t),
        .iv_o        (iv)
    );

    sha2_compress u_comp (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .init_i     (init),
        .seed_i     (seed),
        .round_en_i (round_en),
        .fold_i     (fold),
        .mode_i     (mode),
        .w_t_i      (w_t),
        .k_t_i      (k_t),
        .iv_i       (iv),
        .hash_o     (hash)
    );

    sha2_digest_out u_out (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .digest_load_i (digest_load),
        .mode_i        (mode),
        .hash_i        (hash),
        .out_ready_i   (out_ready_i),
        .out_data_o    (out_data_o),
        .out_valid_o   (out_valid_o),
        .out_busy_o    (out_busy)
    );

endmodule

// ==== bench/sha2_ref.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// takes an already padded byte stream; digest right-aligned in 512 bits
// ~~~~~~~~~~~~~~~~~~~~
`ifndef SHA2_REF_SVH
`define SHA2_REF_SVH

typedef byte unsigned byte_q_t[$];

localparam logic [63:0] REF_K [80] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
};

localparam logic [63:0] REF_IV384 [8] = '{
    64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507, 64'h9159015a3070dd17, 64'h152fecd8f70e5939,
    64'h67332667ffc00b31, 64'h8eb44a8768581511, 64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4
};

localparam logic [63:0] REF_IV512 [8] = '{
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
};

// narrow rotate works on the low 32 bits only
function automatic logic [63:0] ror(input logic [63:0] x, input int n, input bit wide);
    if (wide) begin
        return (x >> n) | (x << (64 - n));
    end
    return {32'b0, (x[31:0] >> n) | (x[31:0] << (32 - n))};
endfunction

function automatic logic [511:0] sha2_ref(input logic [1:0] mode, input byte_q_t msg);
    logic [63:0]  h [8];
    logic [63:0]  v [8];
    logic [63:0]  w [80];
    logic [63:0]  mask;
    logic [63:0]  s0;
    logic [63:0]  s1;
    logic [63:0]  ch;
    logic [63:0]  maj;
    logic [63:0]  k;
    logic [63:0]  t1;
    logic [63:0]  t2;
    logic [511:0] dig;
    bit           wide;
    int           wb;
    int           rounds;
    int           nblk;
    int           n;
    wide   = mode[1];
    wb     = wide ? 8 : 4;
    rounds = wide ? 80 : 64;
    mask   = wide ? '1 : 64'h0000_0000_ffff_ffff;
    for (int i = 0; i < 8; i++) begin
        case (mode)
            2'd0:    h[i] = {32'b0, REF_IV384[i][31:0]};
            2'd1:    h[i] = {32'b0, REF_IV512[i][63:32]};
            2'd2:    h[i] = REF_IV384[i];
            default: h[i] = REF_IV512[i];
        endcase
    end
    nblk = msg.size() / (16 * wb);
    for (int b = 0; b < nblk; b++) begin
        for (int t = 0; t < 16; t++) begin
            w[t] = '0;
            for (int j = 0; j < wb; j++) begin
                w[t] = (w[t] << 8) | 64'(msg[b*16*wb + t*wb + j]); // big-endian words
            end
        end
        for (int t = 16; t < rounds; t++) begin
            if (wide) begin
                s0 = ror(w[t-15], 1, 1) ^ ror(w[t-15], 8, 1) ^ (w[t-15] >> 7);
                s1 = ror(w[t-2], 19, 1) ^ ror(w[t-2], 61, 1) ^ (w[t-2] >> 6);
            end else begin
                s0 = ror(w[t-15], 7, 0) ^ ror(w[t-15], 18, 0) ^ (w[t-15] >> 3);
                s1 = ror(w[t-2], 17, 0) ^ ror(w[t-2], 19, 0) ^ (w[t-2] >> 10);
            end
            w[t] = (s1 + w[t-7] + s0 + w[t-16]) & mask;
        end
        v = h;
        for (int t = 0; t < rounds; t++) begin
            if (wide) begin
                s1 = ror(v[4], 14, 1) ^ ror(v[4], 18, 1) ^ ror(v[4], 41, 1);
                s0 = ror(v[0], 28, 1) ^ ror(v[0], 34, 1) ^ ror(v[0], 39, 1);
            end else begin
                s1 = ror(v[4], 6, 0) ^ ror(v[4], 11, 0) ^ ror(v[4], 25, 0);
                s0 = ror(v[0], 2, 0) ^ ror(v[0], 13, 0) ^ ror(v[0], 22, 0);
            end
            ch   = ((v[4] & v[5]) ^ (~v[4] & v[6])) & mask;
            maj  = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
            k    = wide ? REF_K[t] : {32'b0, REF_K[t][63:32]};
            t1   = (v[7] + s1 + ch + k + w[t]) & mask;
            t2   = (s0 + maj) & mask;
            v[7] = v[6];
            v[6] = v[5];
            v[5] = v[4];
            v[4] = (v[3] + t1) & mask;
            v[3] = v[2];
            v[2] = v[1];
            v[1] = v[0];
            v[0] = (t1 + t2) & mask;
        end
        for (int i = 0; i < 8; i++) begin
            h[i] = (h[i] + v[i]) & mask;
        end
    end
    n   = (mode == 2'd0) ? 7 : ((mode == 2'd2) ? 6 : 8);
    dig = '0;
    for (int i = 0; i < n; i++) begin
        if (wide) begin
            dig[64*(n-1-i) +: 64] = h[i];
        end else begin
            dig[32*(n-1-i) +: 32] = h[i][31:0];
        end
    end
    return dig;
endfunction

`endif

// ==== bench/tb_sha2_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// inputs change 1 unit after the rising edge, outputs sampled on the falling edge
// ~~~~~~~~~~~~~~~~~~~~
module tb_sha2_core;

    `include "sha2_ref.svh"

    localparam int MSG_COUNT   = 32;                 // upper bound over all tests
    localparam int CYCLE_LIMIT = MSG_COUNT * 4 * 100;

    logic                 clk_i;
    logic                 rst_n_i;
    logic [63:0]          in_data_i;
    sha2_pkg::sha2_mode_t in_mode_i;
    logic                 in_last_i;
    logic                 in_valid_i;
    logic                 in_ready_o;
    logic [511:0]         out_data_o;
    logic                 out_valid_o;
    logic                 out_ready_i;

    logic [511:0] exp_q[$];
    int           seed = 35;
    int           rdy_seed = 35;
    int           errors = 0;
    int           err_mark = 0;
    int           test_num = 1;
    int           tests_ok = 0;
    int           tests_bad = 0;
    bit           stall_en = 0;

    sha2_core DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (in_data_i),
        .in_mode_i   (in_mode_i),
        .in_last_i   (in_last_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check(input string what, input logic [511:0] got, input logic [511:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic byte_q_t pad_msg(input logic [1:0] mode, input byte_q_t msg);
        byte_q_t p;
        int      blk;
        int      lenf;
        longint  bits;
        blk  = mode[1] ? 128 : 64;
        lenf = mode[1] ? 16 : 8;
        bits = longint'(msg.size()) * 8;
        p    = msg;
        p.push_back(8'h80);
        while ((p.size() % blk) != blk - lenf) begin
            p.push_back(8'h00);
        end
        for (int i = lenf - 1; i >= 0; i--) begin
            p.push_back((i < 8) ? bits[8*i +: 8] : 8'h00);
        end
        return p;
    endfunction

    // random length that pads out to exactly nblk blocks
    function automatic byte_q_t rand_msg(input logic [1:0] mode, input int nblk);
        byte_q_t m;
        int      blk;
        int      lo;
        int      hi;
        int      len;
        blk = mode[1] ? 128 : 64;
        lo  = blk * (nblk - 1);
        hi  = blk * nblk - (mode[1] ? 17 : 9);
        len = lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
        for (int i = 0; i < len; i++) begin
            m.push_back(8'($random(seed)));
        end
        return m;
    endfunction

    task automatic wait_accept();
        bit taken;
        do begin
            @(negedge clk_i);
            taken = in_ready_o;
            @(posedge clk_i);
            #1;
        end while (!taken);
    endtask

    task automatic send_msg(input logic [1:0] mode, input byte_q_t msg, input bit gaps);
        byte_q_t     p;
        int          wb;
        int          nwords;
        logic [63:0] data;
        p = pad_msg(mode, msg);
        exp_q.push_back(sha2_ref(mode, p));
        wb     = mode[1] ? 8 : 4;
        nwords = p.size() / wb;
        for (int j = 0; j < nwords; j++) begin
            if (gaps && (($random(seed) & 3) == 0)) begin
                in_valid_i = 1'b0;
                repeat (($random(seed) & 3) + 1) @(posedge clk_i);
                #1;
            end
            data = {$random(seed), $random(seed)}; // unused lanes carry junk
            for (int k = 0; k < wb; k++) begin
                data[8*k +: 8] = p[j*wb + k];
            end
            in_data_i  = data;
            in_mode_i  = sha2_pkg::sha2_mode_t'(mode);
            in_last_i  = (j >= nwords - 16);
            in_valid_i = 1'b1;
            wait_accept();
        end
        in_valid_i = 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        @(posedge clk_i);
        #1;
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
        end
        err_mark = errors;
        test_num++;
    endtask

    // digest compare and hold checks
    initial begin : compare_proc
        logic [511:0] held;
        bit           holding;
        holding = 1'b0;
        forever begin
            @(negedge clk_i);
            if (!rst_n_i) begin
                holding = 1'b0;
            end else if (out_valid_o) begin
                check("in_ready_o while digest pending", 512'(in_ready_o), 512'd0);
                if (holding) begin
                    check("out_data_o held under back-pressure", out_data_o, held);
                end
                if (out_ready_i) begin
                    if (exp_q.size() == 0) begin
                        $display("a digest came out with no message outstanding at %0t", $time);
                        errors++;
                    end else begin
                        check("digest", out_data_o, exp_q.pop_front());
                    end
                    holding = 1'b0;
                end else begin
                    held    = out_data_o;
                    holding = 1'b1;
                end
            end
        end
    end

    initial begin : out_ready_drive
        forever begin
            @(posedge clk_i);
            #1;
            out_ready_i = stall_en ? (($random(rdy_seed) & 3) == 0) : 1'b1;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    initial begin
        byte_q_t     abc;
        logic [1:0]  seq [8];
        in_data_i  = '0;
        in_mode_i  = sha2_pkg::SHA_256;
        in_last_i  = 1'b0;
        in_valid_i = 1'b0;
        out_ready_i = 1'b1;
        rst_n_i    = 1'b0;
        abc.push_back(8'h61);
        abc.push_back(8'h62);
        abc.push_back(8'h63);
        seq = '{2'd3, 2'd0, 2'd2, 2'd1, 2'd0, 2'd3, 2'd1, 2'd2};
        repeat (3) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        @(posedge clk_i);
        #1;

        for (int m = 0; m < 4; m++) begin
            send_msg(2'(m), abc, 1'b0);
        end
        finish_test("abc in all modes");

        for (int m = 0; m < 4; m++) begin
            send_msg(2'(m), rand_msg(2'(m), 2), 1'b0);
            send_msg(2'(m), rand_msg(2'(m), 3), 1'b0);
        end
        finish_test("multi-block chaining");

        for (int m = 0; m < 4; m++) begin
            send_msg(2'(m), rand_msg(2'(m), 2), 1'b1);
        end
        finish_test("input valid gaps");

        stall_en = 1'b1;
        for (int m = 0; m < 4; m++) begin
            send_msg(2'(m), rand_msg(2'(m), 1 + m % 2), 1'b0);
        end
        finish_test("output back-pressure");
        stall_en = 1'b0;
        send_msg(2'd1, rand_msg(2'd1, 1), 1'b0);
        finish_test("message after back-pressure");

        for (int i = 0; i < 8; i++) begin
            send_msg(seq[i], rand_msg(seq[i], 1 + i % 2), 1'b0);
        end
        finish_test("mode switching");

        // abandon a 64-bit block once its rounds are under way
        for (int j = 0; j < 16; j++) begin
            in_data_i  = {$random(seed), $random(seed)};
            in_mode_i  = sha2_pkg::SHA_512;
            in_last_i  = 1'b1;
            in_valid_i = 1'b1;
            wait_accept();
        end
        in_valid_i = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        check("in_ready_o during rounds", 512'(in_ready_o), 512'd0);
        @(posedge clk_i);
        #1 rst_n_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        @(negedge clk_i);
        check("in_ready_o after reset", 512'(in_ready_o), 512'd1);
        check("out_valid_o after reset", 512'(out_valid_o), 512'd0);
        @(posedge clk_i);
        #1;
        send_msg(2'd2, abc, 1'b0);
        send_msg(2'd0, rand_msg(2'd0, 2), 1'b0);
        finish_test("reset mid-block");

        $display("tests: %0d ok, %0d failing, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+bench
design/sha2_pkg.sv
design/sha2_const_rom.sv
design/sha2_msg_schedule.sv
design/sha2_compress.sv
design/sha2_round_ctrl.sv
design/sha2_digest_out.sv
design/sha2_core.sv
bench/tb_sha2_core.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_sha2_core -f list.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete"
grep -q "TB PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
